// ==== Makefile ====
SOURCES := $(shell cat tb.f)

.PHONY: run clean

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb | tee sim.log
	grep -qx 'test passed' sim.log

obj_dir/VcpuTb: tb.f $(SOURCES)
	verilator --binary --timing --assert --top-module cpuTb -f tb.f

clean:
	rm -rf obj_dir sim.log

// ==== bench/cpuTb.sv ====
// Multicycle core testbench
`timescale 1ns/1ns

module cpuTb;
	import cpuPkg::*;

	localparam int clockPeriod = 100;
	localparam int resetCycles = 4;
	localparam int eventTarget = 400;
	localparam int watchdogNs = (eventTarget * 64 * 4 + resetCycles) * clockPeriod;

	logic clock;
	logic arstN;
	logic [31:0] instrAddr;
	logic [31:0] instrData;
	logic [31:0] memAddr;
	logic [31:0] memWdata;
	logic memWrite;
	logic [31:0] memRdata;
	logic wbValid;
	logic [4:0] wbAddr;
	logic [31:0] wbData;

	logic [31:0] imem [0:63];
	logic [31:0] dmem [0:63];
	logic [31:0] mRegs [0:31]; // ISA model state
	logic [31:0] mDmem [0:63];
	logic [31:0] mPc;
	integer seed;
	int matched;

	cpuTop u_cpuTop (.*);

	assign instrData = imem[instrAddr[7:2]]; // wraps every 64 words
	assign memRdata = dmem[memAddr[7:2]];

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		abortRun($sformatf("[ERROR] %s: expected %h, got %h", name, expected, actual));
	endtask

	task automatic buildProgram();
		logic [31:0] rnd;
		logic [31:0] rnd2;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] imm;
		logic [15:0] memOff;
		int kind;
		int off;
		int jIdx;
		for (int w = 0; w < 64; w++) begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			rs = {2'b00, rnd[2:0]};
			rt = {2'b00, rnd[5:3]};
			rd = {2'b00, rnd[8:6]};
			memOff = {8'h00, rnd[14:9], 2'b00}; // 0 to 252
			imm = rnd2[15:0];
			kind = int'(rnd2[31:16] % 16'd14);
			off = (w < 63) ? int'(rnd2[15:0]) % (63 - w) : 0; // forward, never past 63
			jIdx = w + 1 + off;
			if (w < 7) begin
				imem[w] = {opAddi, 5'd0, 5'(w + 1), imm}; // seed r1..r7
			end else if (w == 63) begin
				imem[w] = {opAddi, rs, rt, imm};
			end else begin
				case (kind)
					0: imem[w] = {opRtype, rs, rt, rd, 5'd0, fnAdd};
					1: imem[w] = {opRtype, rs, rt, rd, 5'd0, fnSub};
					2: imem[w] = {opRtype, rs, rt, rd, 5'd0, fnAnd};
					3: imem[w] = {opRtype, rs, rt, rd, 5'd0, fnSlt};
					4: imem[w] = {opAddi, rs, rt, imm};
					5: imem[w] = {opAddiu, rs, rt, imm};
					6: imem[w] = {opSlti, rs, rt, imm};
					7: imem[w] = {opLui, rs, rt, imm};
					8: imem[w] = {opLw, 5'd0, rt, memOff};
					9: imem[w] = {opSw, 5'd0, rt, memOff};
					10: imem[w] = {opBeq, rs, rt, off[15:0]};
					11: imem[w] = {opBne, rs, rt, off[15:0]};
					12: imem[w] = {opJ, jIdx[25:0]};
					default: imem[w] = rnd2[0] ? {6'h3f, rnd[25:0]}
						: {opRtype, rs, rt, rd, 5'd0, 6'h25}; // unknown op or funct
				endcase
			end
		end
	endtask

	// one instruction of the ISA model
	task automatic stepModel(output bit produced, output bit isStore,
			output logic [31:0] addr, output logic [31:0] data);
		logic [31:0] instr;
		logic [31:0] immExt;
		logic [31:0] opA;
		logic [31:0] opB;
		logic [4:0] dest;
		instr = imem[mPc[7:2]];
		immExt = {{16{instr[15]}}, instr[15:0]};
		opA = mRegs[instr[25:21]];
		opB = mRegs[instr[20:16]];
		mPc = mPc + 32'd4;
		produced = 1'b1;
		isStore = 1'b0;
		dest = instr[20:16];
		addr = '0;
		data = '0;
		case (instr[31:26])
			opRtype: begin
				dest = instr[15:11];
				case (instr[5:0])
					fnAdd: data = opA + opB;
					fnSub: data = opA - opB;
					fnAnd: data = opA & opB;
					fnSlt: data = {31'd0, $signed(opA) < $signed(opB)};
					default: produced = 1'b0;
				endcase
			end
			opAddi, opAddiu: data = opA + immExt;
			opSlti: data = {31'd0, $signed(opA) < $signed(immExt)};
			opLui: data = {instr[15:0], 16'h0000};
			opLw: begin
				addr = opA + immExt;
				data = mDmem[addr[7:2]];
			end
			opSw: begin
				isStore = 1'b1;
				addr = opA + immExt;
				data = opB;
				mDmem[addr[7:2]] = opB;
			end
			opBeq: begin
				produced = 1'b0;
				if (opA == opB) mPc = mPc + {immExt[29:0], 2'b00};
			end
			opBne: begin
				produced = 1'b0;
				if (opA != opB) mPc = mPc + {immExt[29:0], 2'b00};
			end
			opJ: begin
				produced = 1'b0;
				mPc = {mPc[31:28], instr[25:0], 2'b00};
			end
			default: produced = 1'b0;
		endcase
		if (produced && !isStore) begin
			addr = {27'd0, dest};
			if (dest != 5'd0) mRegs[dest] = data; // r0 stays zero
		end
	endtask

	task automatic nextEvent(output bit isStore, output logic [31:0] addr,
			output logic [31:0] data);
		bit produced;
		int steps;
		produced = 1'b0;
		steps = 0;
		while (!produced) begin
			if (steps == 64) abortRun("model ran a whole program pass with no write or store");
			stepModel(produced, isStore, addr, data);
			steps++;
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	initial begin
		arstN = 1'b0;
		seed = 32'h57331cc4;
		mPc = '0;
		matched = 0;
		for (int i = 0; i < 64; i++) begin
			dmem[i] = 32'h5a5a0000 + i * 32'h01000193; // fill depends on the address
			mDmem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) mRegs[i] = '0;
		buildProgram();
		repeat (resetCycles) @(posedge clock);
		#10 arstN = 1'b1;
	end

	initial begin
		bit expStore;
		logic [31:0] expAddr;
		logic [31:0] expData;
		repeat (resetCycles) begin // last pass is just after release
			@(negedge clock);
			assert (instrAddr == 32'd0) else reportMismatch("instrAddr", 32'd0, instrAddr);
			assert (!memWrite && !wbValid)
				else abortRun("memWrite or wbValid active after reset");
		end
		while (matched < eventTarget) begin
			@(negedge clock);
			if (wbValid) begin
				nextEvent(expStore, expAddr, expData);
				assert (!expStore)
					else abortRun("register write seen where a store was expected");
				assert (wbAddr == expAddr[4:0])
					else reportMismatch("wbAddr", expAddr, {27'd0, wbAddr});
				assert (wbData == expData) else reportMismatch("wbData", expData, wbData);
				matched++;
			end
			if (memWrite) begin
				nextEvent(expStore, expAddr, expData);
				assert (expStore)
					else abortRun("store seen where a register write was expected");
				assert (memAddr == expAddr) else reportMismatch("memAddr", expAddr, memAddr);
				assert (memWdata == expData)
					else reportMismatch("memWdata", expData, memWdata);
				dmem[memAddr[7:2]] = memWdata;
				matched++;
			end
		end
		$display("test passed");
		$finish;
	end

	// watchdog sized for one event per 64 instructions of 4 cycles
	initial begin
		#(watchdogNs);
		abortRun("timeout: the core stopped producing register writes and stores");
	end

endmodule

// ==== tb.f ====
verilog/cpuPkg.sv
verilog/ctrlIf.sv
verilog/controlFsm.sv
verilog/registerFile.sv
verilog/executeUnit.sv
verilog/cpuTop.sv
bench/cpuTb.sv

// ==== verilog/controlFsm.sv ====
// Multicycle control FSM
`timescale 1ns/1ns

module controlFsm (
	input logic clock,
	input logic arstN,
	input cpuPkg::opcodeT opcode,
	input cpuPkg::functT funct,
	input logic zero,
	ctrlIf.fsm ctrl
);
	import cpuPkg::*;

	cpuState state;
	cpuState stateNext;
	logic rtypeKnown;
	aluOpT rtypeOp;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= stateFetch;
		end else begin
			state <= stateNext;
		end
	end

	// funct field to ALU operation
	always_comb begin
		rtypeKnown = 1'b1;
		case (funct)
			fnAdd: rtypeOp = aluAdd;
			fnSub: rtypeOp = aluSub;
			fnAnd: rtypeOp = aluAnd;
			fnSlt: rtypeOp = aluSlt;
			default: begin
				rtypeOp = aluAdd;
				rtypeKnown = 1'b0; // unknown funct runs as a no-op
			end
		endcase
	end

	always_comb begin
		ctrl.pcWrite = 1'b0;
		ctrl.pcSrc = pcAlu;
		ctrl.irWrite = 1'b0;
		ctrl.abLoad = 1'b0;
		ctrl.aluASrc = 1'b0;
		ctrl.aluSrcB = srcFour;
		ctrl.aluOp = aluAdd;
		ctrl.aluOutWrite = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.regDstRt = 1'b0;
		ctrl.wbSrc = wbAlu;
		ctrl.memWrite = 1'b0;
		ctrl.memAddrSrc = 1'b0;
		stateNext = stateFetch;

		case (state)
			stateFetch: begin
				ctrl.irWrite = 1'b1;
				ctrl.pcWrite = 1'b1; // PC + 4 through the ALU
				stateNext = stateDecode;
			end
			stateDecode: begin
				ctrl.abLoad = 1'b1;
				ctrl.aluSrcB = srcBranch;
				ctrl.aluOutWrite = 1'b1; // branch target held for execute
				stateNext = stateExecute;
			end
			stateExecute: begin
				case (opcode)
					opRtype: begin
						if (rtypeKnown) begin
							ctrl.aluASrc = 1'b1;
							ctrl.aluSrcB = srcReg;
							ctrl.aluOp = rtypeOp;
							ctrl.aluOutWrite = 1'b1;
							stateNext = stateWriteback;
						end
					end
					opAddi, opAddiu, opLw, opSw: begin
						ctrl.aluASrc = 1'b1;
						ctrl.aluSrcB = srcImm; // also the load/store address
						ctrl.aluOutWrite = 1'b1;
						stateNext = stateWriteback;
					end
					opSlti: begin
						ctrl.aluASrc = 1'b1;
						ctrl.aluSrcB = srcImm;
						ctrl.aluOp = aluSlt;
						ctrl.aluOutWrite = 1'b1;
						stateNext = stateWriteback;
					end
					opLui: stateNext = stateWriteback; // value formed at write-back
					opBeq, opBne: begin
						ctrl.pcSrc = pcAluOut;
						ctrl.pcWrite = (opcode == opBeq) ? zero : !zero;
					end
					opJ: begin
						ctrl.pcSrc = pcJump;
						ctrl.pcWrite = 1'b1;
					end
					default: stateNext = stateFetch;
				endcase
			end
			stateWriteback: begin
				case (opcode)
					opRtype: ctrl.regWrite = 1'b1;
					opAddi, opAddiu, opSlti: begin
						ctrl.regWrite = 1'b1;
						ctrl.regDstRt = 1'b1;
					end
					opLui: begin
						ctrl.regWrite = 1'b1;
						ctrl.regDstRt = 1'b1;
						ctrl.wbSrc = wbLui;
					end
					opLw: begin
						ctrl.memAddrSrc = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.regDstRt = 1'b1;
						ctrl.wbSrc = wbMem;
					end
					opSw: begin
						ctrl.memAddrSrc = 1'b1;
						ctrl.memWrite = 1'b1; // single-cycle strobe
					end
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			default: stateNext = stateFetch;
		endcase
	end

endmodule

// ==== verilog/cpuPkg.sv ====
// Core-wide types and widths
package cpuPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	typedef enum logic [2:0] {
		stateFetch = 3'd0,
		stateDecode = 3'd1,
		stateExecute = 3'd2,
		stateWriteback = 3'd3
	} cpuState;

	// primary opcodes, standard MIPS encoding
	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opJ = 6'h02,
		opBeq = 6'h04,
		opBne = 6'h05,
		opAddi = 6'h08,
		opAddiu = 6'h09,
		opSlti = 6'h0a,
		opLui = 6'h0f,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeT;

	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [1:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluSlt // signed compare
	} aluOpT;

	typedef enum logic [1:0] {
		srcReg,
		srcImm,
		srcFour,
		srcBranch // immediate shifted by two
	} aluSrcBT;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbLui
	} wbSrcT;

	typedef enum logic [1:0] {
		pcAlu, // live ALU result, used for PC+4
		pcAluOut, // branch target held from decode
		pcJump
	} pcSrcT;

endpackage

// ==== verilog/cpuTop.sv ====
// Multicycle CPU top level
`timescale 1ns/1ns

module cpuTop (
	input logic clock,
	input logic arstN,
	output logic [cpuPkg::dataWidth-1:0] instrAddr,
	input logic [cpuPkg::dataWidth-1:0] instrData,
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic [cpuPkg::dataWidth-1:0] memWdata,
	output logic memWrite,
	input logic [cpuPkg::dataWidth-1:0] memRdata,
	output logic wbValid,
	output logic [cpuPkg::regAddrWidth-1:0] wbAddr,
	output logic [cpuPkg::dataWidth-1:0] wbData
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regA;
	logic [dataWidth-1:0] regB;
	logic [dataWidth-1:0] writeData;
	logic [regAddrWidth-1:0] rs;
	logic [regAddrWidth-1:0] rt;
	logic [regAddrWidth-1:0] rd;
	opcodeT opcode;
	functT funct;
	logic zero;

	ctrlIf ctrlBus ();

	assign memWrite = ctrlBus.memWrite;

	controlFsm u_controlFsm (
		.clock(clock),
		.arstN(arstN),
		.opcode(opcode),
		.funct(funct),
		.zero(zero),
		.ctrl(ctrlBus.fsm)
	);

	registerFile u_registerFile (
		.clock(clock),
		.arstN(arstN),
		.rs(rs),
		.rt(rt),
		.rd(rd),
		.writeData(writeData),
		.ctrl(ctrlBus.datapath),
		.regA(regA),
		.regB(regB),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	executeUnit u_executeUnit (
		.clock(clock),
		.arstN(arstN),
		.instrData(instrData),
		.memRdata(memRdata),
		.regA(regA),
		.regB(regB),
		.ctrl(ctrlBus.datapath),
		.instrAddr(instrAddr),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.writeData(writeData),
		.rs(rs),
		.rt(rt),
		.rd(rd),
		.opcode(opcode),
		.funct(funct),
		.zero(zero)
	);

endmodule

// ==== verilog/ctrlIf.sv ====
// Control word bus
`timescale 1ns/1ns

interface ctrlIf;
	import cpuPkg::*;

	logic pcWrite;
	pcSrcT pcSrc;
	logic irWrite;
	logic abLoad; // latch operands A and B
	logic aluASrc; // 0 PC, 1 register A
	aluSrcBT aluSrcB;
	aluOpT aluOp;
	logic aluOutWrite;
	logic regWrite;
	logic regDstRt; // destination is rt, else rd
	wbSrcT wbSrc;
	logic memWrite;
	logic memAddrSrc; // 0 PC, 1 ALU output register

	modport fsm (
		output pcWrite, pcSrc, irWrite, abLoad, aluASrc, aluSrcB, aluOp,
		output aluOutWrite, regWrite, regDstRt, wbSrc, memWrite, memAddrSrc
	);

	modport datapath (
		input pcWrite, pcSrc, irWrite, abLoad, aluASrc, aluSrcB, aluOp,
		input aluOutWrite, regWrite, regDstRt, wbSrc, memWrite, memAddrSrc
	);

endinterface

// ==== verilog/executeUnit.sv ====
// Datapath with PC, IR and ALU
`timescale 1ns/1ns

module executeUnit (
	input logic clock,
	input logic arstN,
	input logic [cpuPkg::dataWidth-1:0] instrData,
	input logic [cpuPkg::dataWidth-1:0] memRdata,
	input logic [cpuPkg::dataWidth-1:0] regA,
	input logic [cpuPkg::dataWidth-1:0] regB,
	ctrlIf.datapath ctrl,
	output logic [cpuPkg::dataWidth-1:0] instrAddr,
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic [cpuPkg::dataWidth-1:0] memWdata,
	output logic [cpuPkg::dataWidth-1:0] writeData,
	output logic [cpuPkg::regAddrWidth-1:0] rs,
	output logic [cpuPkg::regAddrWidth-1:0] rt,
	output logic [cpuPkg::regAddrWidth-1:0] rd,
	output cpuPkg::opcodeT opcode,
	output cpuPkg::functT funct,
	output logic zero
);
	import cpuPkg::*;

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] ir;
	logic [dataWidth-1:0] aluOut;
	logic [dataWidth-1:0] immExt;
	logic [dataWidth-1:0] jumpTarget;
	logic [dataWidth-1:0] aluA;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] pcNext;

	// instruction fields
	assign opcode = opcodeT'(ir[31:26]);
	assign rs = ir[25:21];
	assign rt = ir[20:16];
	assign rd = ir[15:11];
	assign funct = functT'(ir[5:0]);
	assign immExt = {{16{ir[15]}}, ir[15:0]};
	assign jumpTarget = {pc[31:28], ir[25:0], 2'b00}; // pc already advanced

	assign zero = (regA == regB);
	assign aluA = ctrl.aluASrc ? regA : pc;

	always_comb begin
		case (ctrl.aluSrcB)
			srcReg: aluB = regB;
			srcImm: aluB = immExt;
			srcFour: aluB = dataWidth'(4);
			srcBranch: aluB = {immExt[dataWidth-3:0], 2'b00};
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			aluAdd: aluResult = aluA + aluB;
			aluSub: aluResult = aluA - aluB;
			aluAnd: aluResult = aluA & aluB;
			aluSlt: aluResult = {{(dataWidth-1){1'b0}}, $signed(aluA) < $signed(aluB)};
		endcase
	end

	always_comb begin
		case (ctrl.pcSrc)
			pcAluOut: pcNext = aluOut;
			pcJump: pcNext = jumpTarget;
			default: pcNext = aluResult;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (ctrl.pcWrite) begin
			pc <= pcNext;
		end
	end

	always_ff @(posedge clock) begin
		if (ctrl.irWrite) begin
			ir <= instrData;
		end
		if (ctrl.aluOutWrite) begin
			aluOut <= aluResult;
		end
	end

	assign instrAddr = pc;
	assign memAddr = ctrl.memAddrSrc ? aluOut : pc;
	assign memWdata = regB;

	always_comb begin
		case (ctrl.wbSrc)
			wbMem: writeData = memRdata;
			wbLui: writeData = {ir[15:0], 16'h0000};
			default: writeData = aluOut;
		endcase
	end

endmodule

// ==== verilog/registerFile.sv ====
// Register file with operand latches
`timescale 1ns/1ns

module registerFile (
	input logic clock,
	input logic arstN,
	input logic [cpuPkg::regAddrWidth-1:0] rs,
	input logic [cpuPkg::regAddrWidth-1:0] rt,
	input logic [cpuPkg::regAddrWidth-1:0] rd,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	ctrlIf.datapath ctrl,
	output logic [cpuPkg::dataWidth-1:0] regA,
	output logic [cpuPkg::dataWidth-1:0] regB,
	output logic wbValid,
	output logic [cpuPkg::regAddrWidth-1:0] wbAddr,
	output logic [cpuPkg::dataWidth-1:0] wbData
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [0:2**regAddrWidth-1];
	logic [regAddrWidth-1:0] dest;
	logic [dataWidth-1:0] rsData;
	logic [dataWidth-1:0] rtData;

	assign dest = ctrl.regDstRt ? rt : rd;
	assign rsData = (rs == '0) ? '0 : regs[rs]; // r0 reads zero
	assign rtData = (rt == '0) ? '0 : regs[rt];

	always_ff @(posedge clock) begin
		if (ctrl.regWrite && dest != '0) begin
			regs[dest] <= writeData;
		end
	end

	always_ff @(posedge clock) begin
		if (ctrl.abLoad) begin
			regA <= rsData;
			regB <= rtData;
		end
	end

	// write port seen one cycle later, r0 writes included
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= ctrl.regWrite;
		end
	end

	always_ff @(posedge clock) begin
		if (ctrl.regWrite) begin
			wbAddr <= dest;
			wbData <= writeData;
		end
	end

endmodule
